/* hdl/dnc_addressing_consts.svh */
//////////////////////////////////////////////////////////////////////
// DNC content addressing constants
// Widths, size limits, score shift and clamp, exponent table range
//////////////////////////////////////////////////////////////////////

`ifndef DNC_ADDRESSING_CONSTS_SVH
`define DNC_ADDRESSING_CONSTS_SVH

// Element and type widths
`define DNC_DATA_W    8
`define DNC_SIZE_W    5
`define DNC_BETA_W    8
`define DNC_SIM_W     20
`define DNC_SCORE_W   4
`define DNC_EXP_W     16
`define DNC_SUM_W     20
`define DNC_WEIGHT_W  16

// Matrix limits
`define DNC_MAX_ROWS  16
`define DNC_MAX_COLS  16

// Score = (sim * beta) >>> shift, clamped
`define DNC_SCORE_SHIFT 12
`define DNC_SCORE_MIN   (-8)
`define DNC_SCORE_MAX   (7)

// Exponent table, 2^(score + bias)
`define DNC_EXP_BIAS    8

// Output weight is Q1.15, one divider step per quotient bit
`define DNC_WEIGHT_FRAC 15
`define DNC_DIV_STEPS   16

`endif

/* hdl/dnc_addressing_pkg.sv */
//////////////////////////////////////////////////////////////////////
// DNC content addressing types and stage FSM encodings
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dnc_addressing_consts.svh"

package dnc_addressing_pkg;

  // Key and memory element
  typedef logic signed [`DNC_DATA_W-1:0]   data_t;
  // Row or column count, 1 to 16
  typedef logic        [`DNC_SIZE_W-1:0]   size_t;
  // Key strength, Q4.4
  typedef logic        [`DNC_BETA_W-1:0]   beta_t;
  // Raw dot product of key and row
  typedef logic signed [`DNC_SIM_W-1:0]    sim_t;
  // Clamped score
  typedef logic signed [`DNC_SCORE_W-1:0]  score_t;
  // One-hot power of two
  typedef logic        [`DNC_EXP_W-1:0]    exp_t;
  typedef logic        [`DNC_SUM_W-1:0]    sum_t;
  // Normalized weight, Q1.15
  typedef logic        [`DNC_WEIGHT_W-1:0] weight_t;

  // Similarity stage
  typedef enum logic {load_key, load_rows} sim_state_e;

  // Softmax stage
  typedef enum logic [1:0] {idle, accumulate, divide} norm_state_e;

endpackage

`default_nettype wire

/* hdl/dnc_row_similarity.sv */
//////////////////////////////////////////////////////////////////////
// Row similarity, key buffer and per-row dot product
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dnc_addressing_consts.svh"

module dnc_row_similarity (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            start,
  input  wire dnc_addressing_pkg::size_t size_j,
  input  wire                            k_in_enable,
  input  wire dnc_addressing_pkg::data_t k_in,
  input  wire                            m_in_enable,
  input  wire dnc_addressing_pkg::data_t m_in,
  output logic                           sim_valid,
  output dnc_addressing_pkg::sim_t       sim
);

  localparam int COL_W = $clog2(`DNC_MAX_COLS);

  dnc_addressing_pkg::sim_state_e  state;
  dnc_addressing_pkg::data_t       key_mem [`DNC_MAX_COLS];
  dnc_addressing_pkg::size_t       size_q;
  dnc_addressing_pkg::size_t       last_col;
  logic [COL_W-1:0]                key_idx;
  logic [COL_W-1:0]                col;
  dnc_addressing_pkg::sim_t        acc;
  logic signed [2*`DNC_DATA_W-1:0] prod;
  logic                            start_ok;
  logic                            key_last;
  logic                            col_last;

  assign last_col = size_q - dnc_addressing_pkg::size_t'(1);
  assign key_last = ({1'b0, key_idx} == last_col);
  assign col_last = ({1'b0, col} == last_col);

  // Key word for the current column times the incoming element
  assign prod = key_mem[col] * m_in;

  // Restart only on a word boundary, never in the middle of a key or row
  assign start_ok = start &&
                    ((state == dnc_addressing_pkg::load_key && key_idx == '0) ||
                     (state == dnc_addressing_pkg::load_rows && col == '0));

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= dnc_addressing_pkg::load_key;
      size_q    <= '0;
      key_idx   <= '0;
      col       <= '0;
      acc       <= '0;
      sim_valid <= 1'b0;
    end else begin
      sim_valid <= 1'b0;
      if (start_ok) begin
        state   <= dnc_addressing_pkg::load_key;
        size_q  <= size_j;
        key_idx <= '0;
        col     <= '0;
        acc     <= '0;
      end else begin
        case (state)
          dnc_addressing_pkg::load_key: begin
            if (k_in_enable) begin
              // Last key word, matrix may follow next cycle
              if (key_last) begin
                key_idx <= '0;
                state   <= dnc_addressing_pkg::load_rows;
              end else begin
                key_idx <= key_idx + 1'b1;
              end
            end
          end
          dnc_addressing_pkg::load_rows: begin
            if (m_in_enable) begin
              if (col_last) begin
                // Row done, result goes out with sim
                col       <= '0;
                acc       <= '0;
                sim_valid <= 1'b1;
              end else begin
                col <= col + 1'b1;
                acc <= acc + prod;
              end
            end
          end
          default: state <= dnc_addressing_pkg::load_key;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Key storage and row result
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == dnc_addressing_pkg::load_key && k_in_enable && !start_ok) begin
      key_mem[key_idx] <= k_in;
    end
    // Final column folded in directly
    if (state == dnc_addressing_pkg::load_rows && m_in_enable && col_last && !start_ok) begin
      sim <= acc + prod;
    end
  end

  // Key stream must be over before the matrix stream begins
  assert property (@(posedge CLK) disable iff (RST)
    state == dnc_addressing_pkg::load_rows |-> !k_in_enable)
    else $error("k_in_enable while loading rows");

endmodule

`default_nettype wire

/* hdl/dnc_sharpen_exp2.sv */
//////////////////////////////////////////////////////////////////////
// Sharpening stage, beta scaling, clamp and power-of-two exponent
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dnc_addressing_consts.svh"

module dnc_sharpen_exp2 (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            start,
  input  wire dnc_addressing_pkg::beta_t beta,
  input  wire                            sim_valid,
  input  wire dnc_addressing_pkg::sim_t  sim,
  output logic                           exp_valid,
  output dnc_addressing_pkg::exp_t       exp_val
);

  localparam int PROD_W = `DNC_SIM_W + `DNC_BETA_W + 1;
  localparam int IDX_W  = $clog2(`DNC_EXP_W);

  dnc_addressing_pkg::beta_t  beta_q;
  logic signed [PROD_W-1:0]   product;
  logic signed [PROD_W-1:0]   shifted;
  dnc_addressing_pkg::score_t score;
  logic [IDX_W-1:0]           exp_idx;

  // Beta is unsigned, zero-extend before the signed multiply
  assign product = sim * $signed({1'b0, beta_q});

  // Floor division by 2^12
  assign shifted = product >>> `DNC_SCORE_SHIFT;

  // Saturate to the table range
  always_comb begin
    if (shifted > `DNC_SCORE_MAX) begin
      score = dnc_addressing_pkg::score_t'(`DNC_SCORE_MAX);
    end else if (shifted < `DNC_SCORE_MIN) begin
      score = dnc_addressing_pkg::score_t'(`DNC_SCORE_MIN);
    end else begin
      score = dnc_addressing_pkg::score_t'(shifted);
    end
  end

  // Score -8..7 maps onto bit 0..15
  assign exp_idx = IDX_W'(score + `DNC_EXP_BIAS);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      beta_q    <= '0;
      exp_valid <= 1'b0;
    end else begin
      if (start) begin
        beta_q <= beta;
      end
      exp_valid <= sim_valid;
    end
  end

  // Exponent register, one cycle behind sim
  always_ff @(posedge CLK) begin
    if (sim_valid) begin
      exp_val <= dnc_addressing_pkg::exp_t'(1) << exp_idx;
    end
  end

  // Every exponent handed to the normalizer is an exact power of two
  assert property (@(posedge CLK) disable iff (RST)
    exp_valid |-> $onehot(exp_val))
    else $error("exp_val not a power of two");

endmodule

`default_nettype wire

/* hdl/dnc_softmax_normalize.sv */
//////////////////////////////////////////////////////////////////////
// Softmax normalizer, exponent sum and serial restoring divider
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dnc_addressing_consts.svh"

module dnc_softmax_normalize (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            start,
  input  wire dnc_addressing_pkg::size_t size_i,
  input  wire                            exp_valid,
  input  wire dnc_addressing_pkg::exp_t  exp_val,
  output logic                           c_out_enable,
  output dnc_addressing_pkg::weight_t    c_out,
  output logic                           ready
);

  localparam int IDX_W  = $clog2(`DNC_MAX_ROWS);
  localparam int STEP_W = $clog2(`DNC_DIV_STEPS + 1);

  dnc_addressing_pkg::norm_state_e state;
  dnc_addressing_pkg::exp_t        exp_buf [`DNC_MAX_ROWS];
  dnc_addressing_pkg::size_t       size_q;
  dnc_addressing_pkg::size_t       last_idx;
  dnc_addressing_pkg::size_t       in_cnt;
  dnc_addressing_pkg::size_t       row_cnt;
  logic [STEP_W-1:0]               step;
  dnc_addressing_pkg::sum_t        sum_q;
  dnc_addressing_pkg::sum_t        rem;
  logic [`DNC_DIV_STEPS-1:0]       shreg;
  dnc_addressing_pkg::weight_t     quot;
  logic [`DNC_SUM_W:0]             trial;
  logic                            q_bit;
  logic                            last_step;
  dnc_addressing_pkg::exp_t        cur_exp;

  assign last_idx  = size_q - dnc_addressing_pkg::size_t'(1);
  assign last_step = (step == STEP_W'(`DNC_DIV_STEPS));
  assign cur_exp   = exp_buf[row_cnt[IDX_W-1:0]];

  // Trial subtract on the remainder with the next dividend bit shifted in
  assign trial = {rem, shreg[`DNC_DIV_STEPS-1]} - {1'b0, sum_q};
  assign q_bit = ~trial[`DNC_SUM_W];

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= dnc_addressing_pkg::idle;
      size_q       <= '0;
      in_cnt       <= '0;
      row_cnt      <= '0;
      step         <= '0;
      c_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      c_out_enable <= 1'b0;
      // Weight just emitted was the last one
      ready <= c_out_enable && (state == dnc_addressing_pkg::idle);
      case (state)
        dnc_addressing_pkg::idle: begin
          if (start) begin
            size_q  <= size_i;
            in_cnt  <= '0;
            row_cnt <= '0;
            state   <= dnc_addressing_pkg::accumulate;
          end
        end
        dnc_addressing_pkg::accumulate: begin
          if (exp_valid) begin
            in_cnt <= in_cnt + 1'b1;
            if (in_cnt == last_idx) begin
              step  <= '0;
              state <= dnc_addressing_pkg::divide;
            end
          end
        end
        dnc_addressing_pkg::divide: begin
          // Step 0 is setup, steps 1..16 produce quotient bits
          if (last_step) begin
            step         <= '0;
            c_out_enable <= 1'b1;
            row_cnt      <= row_cnt + 1'b1;
            if (row_cnt == last_idx) begin
              state <= dnc_addressing_pkg::idle;
            end
          end else begin
            step <= step + 1'b1;
          end
        end
        default: state <= dnc_addressing_pkg::idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Exponent buffer, sum and divider datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == dnc_addressing_pkg::idle && start) begin
      sum_q <= '0;
    end
    if (state == dnc_addressing_pkg::accumulate && exp_valid) begin
      exp_buf[in_cnt[IDX_W-1:0]] <= exp_val;
      sum_q                      <= sum_q + dnc_addressing_pkg::sum_t'(exp_val);
    end
    if (state == dnc_addressing_pkg::divide) begin
      if (step == '0) begin
        // Dividend exp * 2^15, its top bits already below the sum
        rem   <= dnc_addressing_pkg::sum_t'(cur_exp >> 1);
        shreg <= {cur_exp[0], {`DNC_WEIGHT_FRAC{1'b0}}};
        quot  <= '0;
      end else begin
        if (q_bit) begin
          rem <= trial[`DNC_SUM_W-1:0];
        end else begin
          rem <= {rem[`DNC_SUM_W-2:0], shreg[`DNC_DIV_STEPS-1]};
        end
        shreg <= shreg << 1;
        quot  <= {quot[`DNC_WEIGHT_W-2:0], q_bit};
        if (last_step) begin
          c_out <= {quot[`DNC_WEIGHT_W-2:0], q_bit};
        end
      end
    end
  end

  // A new request while a run is in flight is dropped
  assert property (@(posedge CLK) disable iff (RST)
    start |-> state == dnc_addressing_pkg::idle)
    else $warning("start while busy ignored");

  // Exponents only arrive while a run is collecting them
  assert property (@(posedge CLK) disable iff (RST)
    exp_valid |-> state == dnc_addressing_pkg::accumulate)
    else $error("exponent outside accumulate");

endmodule

`default_nettype wire

/* hdl/dnc_content_addressing.sv */
//////////////////////////////////////////////////////////////////////
// DNC content addressing, similarity to exponent to softmax pipeline
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dnc_content_addressing (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            start,
  input  wire dnc_addressing_pkg::size_t size_i_in,
  input  wire dnc_addressing_pkg::size_t size_j_in,
  input  wire dnc_addressing_pkg::beta_t beta_in,
  input  wire                            k_in_enable,
  input  wire dnc_addressing_pkg::data_t k_in,
  input  wire                            m_in_enable,
  input  wire dnc_addressing_pkg::data_t m_in,
  output logic                           c_out_enable,
  output dnc_addressing_pkg::weight_t    c_out,
  output logic                           ready
);

  // Similarity to exponent
  logic                     sim_valid;
  dnc_addressing_pkg::sim_t sim;

  // Exponent to normalizer
  logic                     exp_valid;
  dnc_addressing_pkg::exp_t exp_val;

  // Dot product of key with each row
  dnc_row_similarity row_similarity_inst (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_j     (size_j_in),
    .k_in_enable(k_in_enable),
    .k_in       (k_in),
    .m_in_enable(m_in_enable),
    .m_in       (m_in),
    .sim_valid  (sim_valid),
    .sim        (sim)
  );

  // Beta sharpening and 2^score
  dnc_sharpen_exp2 sharpen_exp2_inst (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .beta     (beta_in),
    .sim_valid(sim_valid),
    .sim      (sim),
    .exp_valid(exp_valid),
    .exp_val  (exp_val)
  );

  // Sum and divide, one weight per row
  dnc_softmax_normalize softmax_normalize_inst (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .size_i      (size_i_in),
    .exp_valid   (exp_valid),
    .exp_val     (exp_val),
    .c_out_enable(c_out_enable),
    .c_out       (c_out),
    .ready       (ready)
  );

endmodule

`default_nettype wire

/* testbench/dnc_content_addressing_tb.sv */
//////////////////////////////////////////////////////////////////////
// DNC content addressing testbench
// Streams file vectors through the DUT and compares the weights
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dnc_content_addressing_tb;

  localparam int CLK_PERIOD = 20;
  localparam int VEC_DEPTH  = 512;
  localparam int RST_CYCLES = 3;

  logic                        CLK;
  logic                        RST;
  logic                        start;
  dnc_addressing_pkg::size_t   size_i_in;
  dnc_addressing_pkg::size_t   size_j_in;
  dnc_addressing_pkg::beta_t   beta_in;
  logic                        k_in_enable;
  dnc_addressing_pkg::data_t   k_in;
  logic                        m_in_enable;
  dnc_addressing_pkg::data_t   m_in;
  logic                        c_out_enable;
  dnc_addressing_pkg::weight_t c_out;
  logic                        ready;

  // One 16-bit word per field of the vector file
  logic [15:0] vec_mem [VEC_DEPTH];
  logic [31:0] rng;
  int          watchdog_cycles;
  logic        watchdog_armed;

  // Responses collected by the monitor
  dnc_addressing_pkg::weight_t got_weights [$];
  logic                        ready_seen;
  int                          count_at_ready;

  dnc_content_addressing dnc_content_addressing_inst (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .size_i_in   (size_i_in),
    .size_j_in   (size_j_in),
    .beta_in     (beta_in),
    .k_in_enable (k_in_enable),
    .k_in        (k_in),
    .m_in_enable (m_in_enable),
    .m_in        (m_in),
    .c_out_enable(c_out_enable),
    .c_out       (c_out),
    .ready       (ready)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) CLK = ~CLK;
    end
  end

  // Gap generator for the matrix stream
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string reason);
    $display("Test failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_weight(input string name, input dnc_addressing_pkg::weight_t got,
                              input dnc_addressing_pkg::weight_t expected);
    if (got !== expected) begin
      $display("FAIL %s: got 0x%04h, expected 0x%04h", name, got, expected);
      abort_run("weight mismatch");
    end
  endtask

  task automatic check_count(input string name, input dnc_addressing_pkg::size_t got,
                             input dnc_addressing_pkg::size_t expected);
    if (got !== expected) begin
      $display("FAIL %s: got 0x%02h, expected 0x%02h", name, got, expected);
      abort_run("count mismatch");
    end
  endtask

  // Monitor of the weight stream and ready
  always @(negedge CLK) begin
    if (!RST) begin
      if (c_out_enable) begin
        got_weights.push_back(c_out);
      end
      if (ready) begin
        ready_seen     = 1'b1;
        count_at_ready = got_weights.size();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // One test with start, key, matrix and weight compare
  ////////////////////////////////////////////////////////////////////

  task automatic run_test(input int base, input int test_num, output int next_base);
    dnc_addressing_pkg::size_t si;
    dnc_addressing_pkg::size_t sj;
    logic                      gaps;
    int                        key_base;
    int                        mat_base;
    int                        exp_base;
    int                        gap;
    si       = vec_mem[base][4:0];
    sj       = vec_mem[base+1][4:0];
    gaps     = vec_mem[base+3][0];
    key_base = base + 4;
    mat_base = key_base + sj;
    exp_base = mat_base + si * sj;
    @(negedge CLK);
    start     = 1'b1;
    size_i_in = si;
    size_j_in = sj;
    beta_in   = vec_mem[base+2][7:0];
    @(negedge CLK);
    start = 1'b0;
    for (int j = 0; j < sj; j++) begin
      k_in_enable = 1'b1;
      k_in        = vec_mem[key_base+j][7:0];
      @(negedge CLK);
    end
    k_in_enable = 1'b0;
    // Matrix words with 0 to 2 idle cycles before each when gaps are on
    for (int w = 0; w < si * sj; w++) begin
      if (gaps) begin
        rng         = xorshift32(rng);
        gap         = rng % 3;
        m_in_enable = 1'b0;
        repeat (gap) @(negedge CLK);
      end
      m_in_enable = 1'b1;
      m_in        = vec_mem[mat_base+w][7:0];
      @(negedge CLK);
    end
    m_in_enable = 1'b0;
    // Second start while the divider still has rows left
    if (si > 1) begin
      while (got_weights.size() == 0) @(posedge CLK);
      @(negedge CLK);
      start     = 1'b1;
      size_i_in = 5'd9;
      size_j_in = 5'd7;
      beta_in   = 8'hff;
      @(negedge CLK);
      start = 1'b0;
    end
    while (!ready_seen) @(posedge CLK);
    check_count($sformatf("c_out_enable count before ready, test %0d", test_num),
                dnc_addressing_pkg::size_t'(count_at_ready), si);
    for (int r = 0; r < si; r++) begin
      check_weight($sformatf("c_out row %0d, test %0d", r, test_num),
                   got_weights[r], vec_mem[exp_base+r]);
    end
    got_weights.delete();
    ready_seen = 1'b0;
    next_base  = exp_base + si;
  endtask

  initial begin
    int ptr;
    int next_ptr;
    int test_num;
    int si;
    int sj;
    RST            = 1'b1;
    start          = 1'b0;
    size_i_in      = '0;
    size_j_in      = '0;
    beta_in        = '0;
    k_in_enable    = 1'b0;
    k_in           = '0;
    m_in_enable    = 1'b0;
    m_in           = '0;
    ready_seen     = 1'b0;
    count_at_ready = 0;
    watchdog_armed = 1'b0;
    rng            = 32'hec0a5b94;
    $readmemh("testbench/content_addressing_tests.txt", vec_mem);
    if ($isunknown(vec_mem[0]) || vec_mem[0][4:0] == 0) begin
      $display("No test vectors could be read from the data file");
      abort_run("missing test vectors");
    end
    // Cycle budget from the sizes of all tests
    watchdog_cycles = RST_CYCLES + 10;
    ptr = 0;
    while (vec_mem[ptr][4:0] != 0) begin
      si = vec_mem[ptr][4:0];
      sj = vec_mem[ptr+1][4:0];
      watchdog_cycles += si * sj * 4 + si * 20 + 50;
      ptr += 4 + sj + si * sj + si;
    end
    watchdog_armed = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    ptr      = 0;
    test_num = 0;
    while (vec_mem[ptr][4:0] != 0) begin
      run_test(ptr, test_num, next_ptr);
      ptr = next_ptr;
      test_num++;
    end
    $display("Test passed");
    $finish;
  end

  // Watchdog
  initial begin
    wait (watchdog_armed);
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Timeout, the DUT did not finish all tests within %0d cycles", watchdog_cycles);
    abort_run("watchdog timeout");
  end

endmodule

`default_nettype wire

/* testbench/content_addressing_tests.txt */
// Per test: size_i size_j beta gaps, then key, matrix rows, expected c_out per row
// All hex, key and matrix are signed bytes, a size_i of 0 ends the list
// Single row, weight is always 1.0
0001 0003 0055 0000
05 fa 10
7f 80 03
8000
// Equal rows, random gaps in the matrix stream
0003 0002 0010 0001
01 02
03 04
03 04
03 04
2aaa 2aaa 2aaa
// Score clamped to 7 and -8, plus a zero row
0003 0004 00ff 0000
7f 7f 7f 7f
7f 7f 7f 7f
81 81 81 81
00 00 00 00
7f00 0000 00fe
// Mixed 4x4, beta 1.0, scores 3 -2 1 -6
0004 0004 0010 0000
10 20 f0 08
20 10 00 f8
00 00 11 00
08 08 08 08
f0 e0 10 00
63c0 031e 18f0 0031
// Same 4x4 with random gaps
0004 0004 0010 0001
10 20 f0 08
20 10 00 f8
00 00 11 00
08 08 08 08
f0 e0 10 00
63c0 031e 18f0 0031
// End of list
0000 0000 0000 0000

/* tb.f */
+incdir+hdl
hdl/dnc_addressing_pkg.sv
hdl/dnc_row_similarity.sv
hdl/dnc_sharpen_exp2.sv
hdl/dnc_softmax_normalize.sv
hdl/dnc_content_addressing.sv
testbench/dnc_content_addressing_tb.sv

/* Bender.yml */
package:
  name: dnc_content_addressing

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dnc_addressing_pkg.sv
      - hdl/dnc_row_similarity.sv
      - hdl/dnc_sharpen_exp2.sv
      - hdl/dnc_softmax_normalize.sv
      - hdl/dnc_content_addressing.sv
  - target: simulation
    files:
      - testbench/dnc_content_addressing_tb.sv
